// File: filelist.f
+incdir+hw
hw/core_pkg.sv
hw/reg_file.sv
hw/net_loader.sv
hw/fetch_stage.sv
hw/exec_stage.sv
hw/barrier_unit.sv
hw/core_top.sv
tb/core_properties.sv
tb/core_tb.sv

// File: hw/barrier_unit.sv
`timescale 1ns/1ps
`default_nettype none

module barrier_unit (
    input  wire                    clk,
    input  wire                    n_reset,
    input  wire core_pkg::bar_wr_t mask_wr_i,
    input  wire core_pkg::bar_wr_t bar_wr_i,
    output core_pkg::barrier_t     barrier_o
);

    import core_pkg::*;

    barrier_t mask_r;
    barrier_t bar_r;

    // Mask from the network, barrier value from BAR in execute
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            mask_r <= '0;
            bar_r  <= '0;
        end
        else
        begin
            if (mask_wr_i.en)
            begin
                mask_r <= mask_wr_i.value;
            end
            if (bar_wr_i.en)
            begin
                bar_r <= bar_wr_i.value;
            end
        end
    end

    // A 1 in the mask lets that barrier bit through
    assign barrier_o = mask_r & bar_r;

endmodule

`default_nettype wire

// File: hw/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath word width
`define CORE_DATA_W 32

// Instruction word width
`define CORE_INSTR_W 16

// Instruction memory address width, 256 words deep
`define CORE_IMEM_AW 8

// Register file address width, 32 registers
`define CORE_RF_AW 5

// Barrier and barrier mask width
`define CORE_BAR_W 16

// Network widths
`define CORE_ID_W 10
`define CORE_NET_ADDR_W 10

// Core ID used when the top level is not overridden
`define CORE_NET_ID 1

`endif

// File: hw/core_pkg.sv
`default_nettype none

`include "core_config.svh"

package core_pkg;

    // Network packet commands
    typedef enum logic [2:0] {
        NET_NONE  = 3'd0,
        NET_INSTR = 3'd1,
        NET_REG   = 3'd2,
        NET_PC    = 3'd3,
        NET_BAR   = 3'd4
    } net_op_e;

    // One-cycle command word from the network
    typedef struct packed {
        logic [`CORE_ID_W-1:0]       id;
        net_op_e                     op;
        logic [`CORE_NET_ADDR_W-1:0] addr;
        logic [`CORE_DATA_W-1:0]     data;
    } net_packet_t;

    // All-zero word is NOP
    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_ADDU  = 5'd1,
        OP_SUBU  = 5'd2,
        OP_AND   = 5'd3,
        OP_OR    = 5'd4,
        OP_MOV   = 5'd5,
        OP_ADDI  = 5'd6,
        OP_BEQZ  = 5'd7,
        OP_BNEQZ = 5'd8,
        OP_BAR   = 5'd9,
        OP_WAIT  = 5'd10
    } opcode_e;

    // Register form, rd op rs
    typedef struct packed {
        opcode_e                opcode;
        logic [`CORE_RF_AW-1:0] rd;
        logic                   spare;
        logic [`CORE_RF_AW-1:0] rs;
    } instr_r_t;

    // Immediate form, used by ADDI and the branches
    typedef struct packed {
        opcode_e                opcode;
        logic [`CORE_RF_AW-1:0] rd;
        logic signed [5:0]      imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        logic                     valid;
        logic [`CORE_IMEM_AW-1:0] pc;
        instr_u                   instr;
    } if_id_t;

    typedef struct packed {
        logic                     taken;
        logic [`CORE_IMEM_AW-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                     en;
        logic [`CORE_IMEM_AW-1:0] addr;
        logic [`CORE_INSTR_W-1:0] instr;
    } imem_wr_t;

    typedef struct packed {
        logic                    en;
        logic [`CORE_RF_AW-1:0]  addr;
        logic [`CORE_DATA_W-1:0] data;
    } rf_wr_t;

    typedef struct packed {
        logic                     en;
        logic [`CORE_IMEM_AW-1:0] pc;
    } pc_start_t;

    typedef struct packed {
        logic                   en;
        logic [`CORE_BAR_W-1:0] value;
    } bar_wr_t;

    typedef logic [`CORE_BAR_W-1:0] barrier_t;

endpackage

`default_nettype wire

// File: hw/core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module core_top #(
    parameter logic [`CORE_ID_W-1:0] NET_ID = `CORE_NET_ID
)
(
    input  wire                      clk,
    input  wire                      n_reset,
    input  wire core_pkg::net_packet_t net_packet_i,
    output core_pkg::barrier_t       barrier_o,
    output logic                     idle_o
);

    import core_pkg::*;

    // Loader commands
    imem_wr_t  imem_wr;
    rf_wr_t    rf_wr;
    pc_start_t start;
    bar_wr_t   mask_wr;
    logic      run;

    // Pipeline links
    logic      wait_retired;
    if_id_t    if_id;
    redirect_t redirect;
    bar_wr_t   bar_wr;

    net_loader #(
        .NET_ID(NET_ID)
    ) i_net_loader (
        .clk           (clk),
        .n_reset       (n_reset),
        .net_packet_i  (net_packet_i),
        .wait_retired_i(wait_retired),
        .imem_wr_o     (imem_wr),
        .rf_wr_o       (rf_wr),
        .start_o       (start),
        .mask_wr_o     (mask_wr),
        .run_o         (run),
        .idle_o        (idle_o)
    );

    fetch_stage i_fetch_stage (
        .clk       (clk),
        .n_reset   (n_reset),
        .run_i     (run),
        .start_i   (start),
        .imem_wr_i (imem_wr),
        .redirect_i(redirect),
        .if_id_o   (if_id)
    );

    exec_stage i_exec_stage (
        .clk           (clk),
        .n_reset       (n_reset),
        .run_i         (run),
        .if_id_i       (if_id),
        .rf_wr_i       (rf_wr),
        .redirect_o    (redirect),
        .bar_wr_o      (bar_wr),
        .wait_retired_o(wait_retired)
    );

    barrier_unit i_barrier_unit (
        .clk      (clk),
        .n_reset  (n_reset),
        .mask_wr_i(mask_wr),
        .bar_wr_i (bar_wr),
        .barrier_o(barrier_o)
    );

endmodule

`default_nettype wire

// File: hw/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module exec_stage (
    input  wire                      clk,
    input  wire                      n_reset,
    input  wire                      run_i,
    input  wire core_pkg::if_id_t    if_id_i,
    input  wire core_pkg::rf_wr_t    rf_wr_i,
    output core_pkg::redirect_t      redirect_o,
    output core_pkg::bar_wr_t        bar_wr_o,
    output logic                     wait_retired_o
);

    import core_pkg::*;

    // Decode
    instr_u                   id_instr;
    opcode_e                  id_op;
    logic [`CORE_RF_AW-1:0]   id_rd_addr;
    logic [`CORE_RF_AW-1:0]   id_rs_addr;
    logic                     id_valid;
    logic                     id_writes;
    logic [`CORE_DATA_W-1:0]  rf_rd_val;
    logic [`CORE_DATA_W-1:0]  rf_rs_val;
    logic [`CORE_DATA_W-1:0]  id_rd_val;
    logic [`CORE_DATA_W-1:0]  id_rs_val;
    // ID/EX
    logic                     ex_valid;
    opcode_e                  ex_op;
    logic [`CORE_IMEM_AW-1:0] ex_pc;
    logic [`CORE_RF_AW-1:0]   ex_rd_addr;
    logic                     ex_writes;
    logic [`CORE_DATA_W-1:0]  ex_rd_val;
    logic [`CORE_DATA_W-1:0]  ex_rs_val;
    logic signed [5:0]        ex_imm;
    logic                     ex_fwd;
    logic [`CORE_DATA_W-1:0]  alu_res;
    logic                     br_cond;
    // EX/WB
    rf_wr_t                   wb_wr;
    logic                     wb_wait;

    assign id_instr   = if_id_i.instr;
    assign id_op      = id_instr.r.opcode;
    assign id_rd_addr = id_instr.r.rd;
    assign id_rs_addr = id_instr.r.rs;

    // A taken branch in execute squashes decode
    assign id_valid  = if_id_i.valid && run_i && !redirect_o.taken;
    // Writes to r0 are dropped so forwarding never sees them
    assign id_writes = (id_op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_MOV, OP_ADDI})
                       && (id_rd_addr != '0);

    reg_file i_reg_file (
        .clk      (clk),
        .rs_addr_i(id_rs_addr),
        .rd_addr_i(id_rd_addr),
        .net_wr_i (rf_wr_i),
        .wb_wr_i  (wb_wr),
        .rs_val_o (rf_rs_val),
        .rd_val_o (rf_rd_val)
    );

    // Forward from execute first, then writeback
    assign ex_fwd    = ex_valid && ex_writes;
    assign id_rd_val = (ex_fwd && (ex_rd_addr == id_rd_addr)) ? alu_res
                     : (wb_wr.en && (wb_wr.addr == id_rd_addr)) ? wb_wr.data : rf_rd_val;
    assign id_rs_val = (ex_fwd && (ex_rd_addr == id_rs_addr)) ? alu_res
                     : (wb_wr.en && (wb_wr.addr == id_rs_addr)) ? wb_wr.data : rf_rs_val;

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            ex_valid <= 1'b0;
            wb_wr.en <= 1'b0;
            wb_wait  <= 1'b0;
        end
        else
        begin
            ex_valid <= id_valid;
            wb_wr.en <= ex_fwd;
            wb_wait  <= ex_valid && (ex_op == OP_WAIT);
        end
    end

    // Payload of both pipeline registers
    always_ff @(posedge clk)
    begin
        ex_op      <= id_op;
        ex_pc      <= if_id_i.pc;
        ex_rd_addr <= id_rd_addr;
        ex_writes  <= id_writes;
        ex_rd_val  <= id_rd_val;
        ex_rs_val  <= id_rs_val;
        ex_imm     <= id_instr.i.imm;
        wb_wr.addr <= ex_rd_addr;
        wb_wr.data <= alu_res;
    end

    // ALU and branch condition, both test rd
    always_comb
    begin
        alu_res = ex_rs_val;
        br_cond = 1'b0;
        case (ex_op)
            OP_ADDU:  alu_res = ex_rd_val + ex_rs_val;
            OP_SUBU:  alu_res = ex_rd_val - ex_rs_val;
            OP_AND:   alu_res = ex_rd_val & ex_rs_val;
            OP_OR:    alu_res = ex_rd_val | ex_rs_val;
            OP_ADDI:  alu_res = ex_rd_val + {{(`CORE_DATA_W-6){ex_imm[5]}}, ex_imm};
            OP_BEQZ:  br_cond = (ex_rd_val == '0);
            OP_BNEQZ: br_cond = (ex_rd_val != '0);
            default:  alu_res = ex_rs_val;
        endcase
    end

    // Target relative to the branch's own PC
    assign redirect_o.taken  = ex_valid && br_cond;
    assign redirect_o.target = ex_pc + {{(`CORE_IMEM_AW-6){ex_imm[5]}}, ex_imm};

    assign bar_wr_o.en    = ex_valid && (ex_op == OP_BAR);
    assign bar_wr_o.value = ex_rs_val[`CORE_BAR_W-1:0];

    assign wait_retired_o = wb_wait;

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module fetch_stage (
    input  wire                      clk,
    input  wire                      n_reset,
    input  wire                      run_i,
    input  wire core_pkg::pc_start_t start_i,
    input  wire core_pkg::imem_wr_t  imem_wr_i,
    input  wire core_pkg::redirect_t redirect_i,
    output core_pkg::if_id_t         if_id_o
);

    import core_pkg::*;

    localparam int IMEM_DEPTH = 1 << `CORE_IMEM_AW;

    logic [`CORE_INSTR_W-1:0] imem [IMEM_DEPTH];
    logic [`CORE_IMEM_AW-1:0] pc_r;
    logic                     hold_r;
    logic                     wait_in_id;
    logic                     issue;
    if_id_t                   if_id_r;

    // WAIT just fetched and now sitting in decode
    assign wait_in_id = if_id_r.valid && (if_id_r.instr.r.opcode == OP_WAIT);

    // Issue a real fetch only when running and nothing blocks it
    assign issue = run_i && !hold_r && !wait_in_id && !redirect_i.taken;

    // Next PC, start first, then redirect, then sequential
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            pc_r <= '0;
        end
        else if (start_i.en)
        begin
            pc_r <= start_i.pc;
        end
        else if (redirect_i.taken)
        begin
            pc_r <= redirect_i.target;
        end
        else if (issue)
        begin
            pc_r <= pc_r + 1'b1;
        end
    end

    // Hold after WAIT until redirected or back in IDLE
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            hold_r <= 1'b0;
        end
        else if (redirect_i.taken || !run_i)
        begin
            hold_r <= 1'b0;
        end
        else if (wait_in_id)
        begin
            hold_r <= 1'b1;
        end
    end

    // Valid bit of IF/ID, a redirect kills the wrong-path fetch
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            if_id_r.valid <= 1'b0;
        end
        else
        begin
            if_id_r.valid <= issue;
        end
    end

    // Instruction memory, network write port and synchronous read
    always_ff @(posedge clk)
    begin
        if (imem_wr_i.en)
        begin
            imem[imem_wr_i.addr] <= imem_wr_i.instr;
        end
        if_id_r.instr <= imem[pc_r];
        if_id_r.pc    <= pc_r;
    end

    assign if_id_o = if_id_r;

endmodule

`default_nettype wire

// File: hw/net_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module net_loader #(
    parameter logic [`CORE_ID_W-1:0] NET_ID = `CORE_NET_ID
)
(
    input  wire                        clk,
    input  wire                        n_reset,
    input  wire core_pkg::net_packet_t net_packet_i,
    input  wire                        wait_retired_i,
    output core_pkg::imem_wr_t         imem_wr_o,
    output core_pkg::rf_wr_t           rf_wr_o,
    output core_pkg::pc_start_t        start_o,
    output core_pkg::bar_wr_t          mask_wr_o,
    output logic                       run_o,
    output logic                       idle_o
);

    import core_pkg::*;

    logic id_match;
    logic run_r;

    // Packet addressed to this core
    assign id_match = (net_packet_i.id == NET_ID);

    // Loads and start only while idle, the mask at any time
    assign imem_wr_o.en    = id_match && (net_packet_i.op == NET_INSTR) && !run_r;
    assign imem_wr_o.addr  = net_packet_i.addr[`CORE_IMEM_AW-1:0];
    assign imem_wr_o.instr = net_packet_i.data[`CORE_INSTR_W-1:0];

    assign rf_wr_o.en   = id_match && (net_packet_i.op == NET_REG) && !run_r;
    assign rf_wr_o.addr = net_packet_i.addr[`CORE_RF_AW-1:0];
    assign rf_wr_o.data = net_packet_i.data;

    assign start_o.en = id_match && (net_packet_i.op == NET_PC) && !run_r;
    assign start_o.pc = net_packet_i.addr[`CORE_IMEM_AW-1:0];

    assign mask_wr_o.en    = id_match && (net_packet_i.op == NET_BAR);
    assign mask_wr_o.value = net_packet_i.data[`CORE_BAR_W-1:0];

    // IDLE/RUN state, run_r high means RUN
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            run_r <= 1'b0;
        end
        else if (start_o.en)
        begin
            run_r <= 1'b1;
        end
        else if (wait_retired_i)
        begin
            // WAIT reached writeback, nothing older is left
            run_r <= 1'b0;
        end
    end

    assign run_o  = run_r;
    assign idle_o = !run_r;

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module reg_file (
    input  wire                          clk,
    input  wire [`CORE_RF_AW-1:0]        rs_addr_i,
    input  wire [`CORE_RF_AW-1:0]        rd_addr_i,
    input  wire core_pkg::rf_wr_t        net_wr_i,
    input  wire core_pkg::rf_wr_t        wb_wr_i,
    output logic [`CORE_DATA_W-1:0]      rs_val_o,
    output logic [`CORE_DATA_W-1:0]      rd_val_o
);

    logic [`CORE_DATA_W-1:0] regs [1 << `CORE_RF_AW];

    // Loader writes only in IDLE, writeback only in RUN
    always_ff @(posedge clk)
    begin
        if (net_wr_i.en)
        begin
            regs[net_wr_i.addr] <= net_wr_i.data;
        end
        else if (wb_wr_i.en)
        begin
            regs[wb_wr_i.addr] <= wb_wr_i.data;
        end
    end

    // r0 is hardwired to zero
    assign rs_val_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rd_val_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule

`default_nettype wire

// File: tb/core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module core_properties (
    input wire                      clk,
    input wire                      n_reset,
    input wire                      idle_i,
    input wire                      run_i,
    input wire core_pkg::pc_start_t start_i,
    input wire core_pkg::bar_wr_t   mask_wr_i,
    input wire core_pkg::imem_wr_t  imem_wr_i,
    input wire core_pkg::barrier_t  barrier_i
);

    import core_pkg::*;

    logic     started;
    barrier_t last_mask;
    int       idle_errs = 0;
    int       mask_errs = 0;
    int       imem_errs = 0;
    int       error_count;

    // First start command seen and the mask the barrier unit holds
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            started   <= 1'b0;
            last_mask <= '0;
        end
        else
        begin
            if (start_i.en)
            begin
                started <= 1'b1;
            end
            if (mask_wr_i.en)
            begin
                last_mask <= mask_wr_i.value;
            end
        end
    end

    assign error_count = idle_errs + mask_errs + imem_errs;

    // Core stays in IDLE until a PC packet arrives
    idle_before_start: assert property (@(posedge clk) disable iff (!n_reset)
        !started |-> idle_i)
    else
    begin
        idle_errs++;
        $error("idle_o fell before the first PC packet");
    end

    // Barrier bits only pass where the mask is set
    barrier_in_mask: assert property (@(posedge clk) disable iff (!n_reset)
        (barrier_i & ~last_mask) == '0)
    else
    begin
        mask_errs++;
        $error("barrier_o has a bit set outside the mask");
    end

    // Program memory is frozen while the core runs
    no_imem_write_in_run: assert property (@(posedge clk) disable iff (!n_reset)
        run_i |-> !imem_wr_i.en)
    else
    begin
        imem_errs++;
        $error("instruction memory written while running");
    end

endmodule

bind core_top core_properties i_core_properties (
    .clk      (clk),
    .n_reset  (n_reset),
    .idle_i   (idle_o),
    .run_i    (run),
    .start_i  (start),
    .mask_wr_i(mask_wr),
    .imem_wr_i(imem_wr),
    .barrier_i(barrier_o)
);

`default_nettype wire

// File: tb/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module core_tb;

    import core_pkg::*;

    localparam logic [`CORE_ID_W-1:0] CORE_ID = `CORE_NET_ID;
    localparam logic [`CORE_ID_W-1:0] OTHER_ID = `CORE_NET_ID + 1;
    localparam int RUN_TIMEOUT = 2000;

    logic        clk;
    logic        n_reset;
    net_packet_t net_packet;
    barrier_t    barrier;
    logic        idle;

    // Mirror of what has been loaded into the core
    logic [`CORE_INSTR_W-1:0] prog_mem [1 << `CORE_IMEM_AW];
    logic [`CORE_DATA_W-1:0]  reg_init [1 << `CORE_RF_AW];
    barrier_t                 cur_mask;
    opcode_e                  alu_ops [6];

    // Handshake with the compare process
    logic     cmp_pending;
    barrier_t cmp_expect;
    string    cmp_label;

    core_top #(
        .NET_ID(CORE_ID)
    ) i_core_top (
        .clk         (clk),
        .n_reset     (n_reset),
        .net_packet_i(net_packet),
        .barrier_o   (barrier),
        .idle_o      (idle)
    );

    always #2 clk = ~clk;

    function automatic logic [15:0] encode_r(input opcode_e op, input logic [4:0] rd,
                                             input logic [4:0] rs);
        return {op, rd, 1'b0, rs};
    endfunction

    function automatic logic [15:0] encode_i(input opcode_e op, input logic [4:0] rd,
                                             input logic [5:0] imm);
        return {op, rd, imm};
    endfunction

    // Instruction-set model, one instruction at a time up to WAIT
    function automatic barrier_t model_run(input logic [`CORE_IMEM_AW-1:0] start_pc);
        logic [`CORE_DATA_W-1:0]  r [1 << `CORE_RF_AW];
        logic [`CORE_IMEM_AW-1:0] pc;
        logic [15:0]              word;
        logic [4:0]               op;
        logic [4:0]               rd;
        logic [4:0]               rs;
        logic [`CORE_DATA_W-1:0]  imm;
        logic [`CORE_DATA_W-1:0]  res;
        logic                     wr;
        logic                     taken;
        logic                     done;
        barrier_t                 bar;
        int                       steps;
        for (int k = 0; k < 32; k++)
        begin
            r[k] = reg_init[k];
        end
        r[0]  = '0;
        pc    = start_pc;
        done  = 1'b0;
        bar   = '0;
        steps = 0;
        while (!done && steps < 10000)
        begin
            word  = prog_mem[pc];
            op    = word[15:11];
            rd    = word[10:6];
            rs    = word[4:0];
            imm   = {{26{word[5]}}, word[5:0]};
            wr    = 1'b1;
            taken = 1'b0;
            res   = '0;
            case (op)
                OP_ADDU:  res = r[rd] + r[rs];
                OP_SUBU:  res = r[rd] - r[rs];
                OP_AND:   res = r[rd] & r[rs];
                OP_OR:    res = r[rd] | r[rs];
                OP_MOV:   res = r[rs];
                OP_ADDI:  res = r[rd] + imm;
                OP_BEQZ:
                begin
                    wr    = 1'b0;
                    taken = (r[rd] == '0);
                end
                OP_BNEQZ:
                begin
                    wr    = 1'b0;
                    taken = (r[rd] != '0);
                end
                OP_BAR:
                begin
                    wr  = 1'b0;
                    bar = r[rs][15:0];
                end
                OP_WAIT:
                begin
                    wr   = 1'b0;
                    done = 1'b1;
                end
                default:  wr = 1'b0;
            endcase
            // r0 is never written
            if (wr && rd != 5'd0)
            begin
                r[rd] = res;
            end
            pc    = taken ? pc + imm[7:0] : pc + 8'd1;
            steps = steps + 1;
        end
        return bar;
    endfunction

    task automatic check_barrier(input barrier_t exp, input string what);
        if (barrier !== exp)
        begin
            $display("CHECK FAILED at %0t: %s, barrier_o %h, expected %h",
                     $time, what, barrier, exp);
            $display("tests failed");
            $fatal(1, "barrier mismatch");
        end
    endtask

    task automatic check_idle(input logic exp, input string what);
        if (idle !== exp)
        begin
            $display("CHECK FAILED at %0t: %s, idle_o %b, expected %b", $time, what, idle, exp);
            $display("tests failed");
            $fatal(1, "idle mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("tests failed");
        $fatal(1, "timeout");
    endtask

    // Compares barrier_o at the falling edge where it is stable
    always @(negedge clk)
    begin
        if (cmp_pending === 1'b1)
        begin
            check_barrier(cmp_expect, cmp_label);
            cmp_pending = 1'b0;
        end
    end

    // Any failed assertion in the bound checker ends the run
    always @(negedge clk)
    begin
        if (i_core_top.i_core_properties.error_count != 0)
        begin
            $display("Assertion failed before %0t", $time);
            $display("tests failed");
            $fatal(1, "assertion failure");
        end
    end

    task automatic request_compare(input barrier_t exp, input string what);
        int n;
        cmp_expect  = exp;
        cmp_label   = what;
        cmp_pending = 1'b1;
        n = 0;
        while (cmp_pending && n < 4)
        begin
            @(posedge clk);
            #0.5;
            n++;
        end
        if (cmp_pending)
        begin
            report_timeout("compare process never answered");
        end
    endtask

    // Entered and left 0.5 ns after a rising edge, one cycle per packet
    task automatic send_packet(input logic [9:0] id, input net_op_e op,
                               input logic [9:0] addr, input logic [31:0] data);
        net_packet.id   = id;
        net_packet.op   = op;
        net_packet.addr = addr;
        net_packet.data = data;
        @(posedge clk);
        #0.5;
        net_packet = '0;
    endtask

    task automatic load_program(input logic [7:0] base, input int len);
        for (int k = 0; k < len; k++)
        begin
            send_packet(CORE_ID, NET_INSTR, 10'(base + k), 32'(prog_mem[8'(base + k)]));
        end
    endtask

    task automatic fill_random_regs();
        for (int k = 1; k < 32; k++)
        begin
            reg_init[k] = $urandom();
        end
    endtask

    task automatic preload_regs();
        for (int k = 1; k < 32; k++)
        begin
            send_packet(CORE_ID, NET_REG, 10'(k), reg_init[k]);
        end
    endtask

    task automatic set_mask(input barrier_t m);
        send_packet(CORE_ID, NET_BAR, 10'd0, 32'(m));
        cur_mask = m;
    endtask

    task automatic start_program(input logic [7:0] pc);
        send_packet(CORE_ID, NET_PC, 10'(pc), 32'd0);
        check_idle(1'b0, "core left IDLE after PC packet");
    endtask

    task automatic wait_for_idle();
        int n;
        n = 0;
        while (idle !== 1'b1 && n < RUN_TIMEOUT)
        begin
            @(posedge clk);
            #0.5;
            n++;
        end
        if (idle !== 1'b1)
        begin
            report_timeout("core did not return to IDLE within 2000 cycles");
        end
    endtask

    task automatic run_to_idle(input logic [7:0] pc);
        start_program(pc);
        wait_for_idle();
    endtask

    // 20 random ALU and ADDI ops, then BAR on the last result and WAIT
    task automatic write_random_program(input logic [7:0] base);
        opcode_e    op;
        logic [4:0] rd;
        rd = '0;
        for (int k = 0; k < 20; k++)
        begin
            op = alu_ops[$urandom_range(5, 0)];
            rd = 5'($urandom_range(31, 0));
            if (op == OP_ADDI)
                prog_mem[8'(base + k)] = encode_i(op, rd, 6'($urandom()));
            else
                prog_mem[8'(base + k)] = encode_r(op, rd, 5'($urandom_range(31, 0)));
        end
        prog_mem[8'(base + 20)] = encode_r(OP_BAR, 5'd0, rd);
        prog_mem[8'(base + 21)] = encode_r(OP_WAIT, 5'd0, 5'd0);
    endtask

    // Back-to-back dependences through EX and WB, plus r0 as target
    task automatic write_forward_chain(input logic [7:0] base);
        prog_mem[base + 0]  = encode_i(OP_ADDI, 5'd1, 6'd7);
        prog_mem[base + 1]  = encode_r(OP_ADDU, 5'd1, 5'd1);
        prog_mem[base + 2]  = encode_r(OP_MOV, 5'd2, 5'd1);
        prog_mem[base + 3]  = encode_i(OP_ADDI, 5'd2, 6'h3d);
        prog_mem[base + 4]  = encode_r(OP_OR, 5'd3, 5'd1);
        prog_mem[base + 5]  = encode_r(OP_AND, 5'd3, 5'd2);
        prog_mem[base + 6]  = encode_r(OP_SUBU, 5'd4, 5'd3);
        prog_mem[base + 7]  = encode_r(OP_ADDU, 5'd4, 5'd4);
        prog_mem[base + 8]  = 16'h0000;
        prog_mem[base + 9]  = encode_r(OP_ADDU, 5'd4, 5'd2);
        prog_mem[base + 10] = encode_r(OP_MOV, 5'd0, 5'd5);
        prog_mem[base + 11] = encode_r(OP_ADDU, 5'd6, 5'd0);
        prog_mem[base + 12] = encode_r(OP_OR, 5'd6, 5'd4);
        prog_mem[base + 13] = encode_r(OP_BAR, 5'd0, 5'd6);
        prog_mem[base + 14] = encode_r(OP_WAIT, 5'd0, 5'd0);
    endtask

    // Sum r2 down to 1 into r1, wrong-path ADDIs after both branches
    task automatic write_countdown_loop(input logic [7:0] base);
        prog_mem[base + 0] = encode_r(OP_MOV, 5'd1, 5'd0);
        prog_mem[base + 1] = encode_r(OP_ADDU, 5'd1, 5'd2);
        prog_mem[base + 2] = encode_i(OP_ADDI, 5'd2, 6'h3f);
        prog_mem[base + 3] = encode_i(OP_BNEQZ, 5'd2, 6'h3e);
        prog_mem[base + 4] = encode_i(OP_ADDI, 5'd1, 6'd16);
        prog_mem[base + 5] = encode_i(OP_BEQZ, 5'd2, 6'd3);
        prog_mem[base + 6] = encode_i(OP_ADDI, 5'd1, 6'd1);
        prog_mem[base + 7] = encode_i(OP_ADDI, 5'd1, 6'd2);
        prog_mem[base + 8] = encode_r(OP_BAR, 5'd0, 5'd1);
        prog_mem[base + 9] = encode_r(OP_WAIT, 5'd0, 5'd0);
    endtask

    initial
    begin
        logic [7:0] base;
        barrier_t   last_bar;
        clk         = 1'b0;
        n_reset     = 1'b0;
        net_packet  = '0;
        cmp_pending = 1'b0;
        cmp_expect  = '0;
        cmp_label   = "";
        cur_mask    = '0;
        alu_ops     = '{OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_MOV, OP_ADDI};
        for (int k = 0; k < 256; k++)
        begin
            prog_mem[k] = '0;
        end
        for (int k = 0; k < 32; k++)
        begin
            reg_init[k] = '0;
        end
        void'($urandom(32'h7dc6));
        repeat (8) @(posedge clk);
        #0.5;
        n_reset = 1'b1;
        @(posedge clk);
        #0.5;

        // Reset state
        check_idle(1'b1, "idle after reset");
        request_compare('0, "barrier after reset");
        set_mask(16'hffff);

        // Random straight-line programs
        for (int t = 0; t < 6; t++)
        begin
            base = 8'($urandom_range(200, 0));
            fill_random_regs();
            preload_regs();
            write_random_program(base);
            load_program(base, 22);
            run_to_idle(base);
            request_compare(cur_mask & model_run(base), "random program");
        end

        // Directed forwarding chain
        fill_random_regs();
        preload_regs();
        write_forward_chain(8'd32);
        load_program(8'd32, 15);
        run_to_idle(8'd32);
        request_compare(cur_mask & model_run(8'd32), "forwarding chain");

        // Count-down loop with squashed instructions
        fill_random_regs();
        reg_init[2] = 32'(5 + $urandom_range(10, 0));
        preload_regs();
        write_countdown_loop(8'd64);
        load_program(8'd64, 10);
        run_to_idle(8'd64);
        last_bar = model_run(8'd64);
        request_compare(cur_mask & last_bar, "count-down loop");
        check_idle(1'b1, "idle after loop");

        // New mask, then packets for another core
        set_mask(16'h0f0f);
        request_compare(16'h0f0f & last_bar, "new mask");
        send_packet(OTHER_ID, NET_BAR, 10'd0, 32'hffff);
        request_compare(16'h0f0f & last_bar, "mask packet for another core");
        send_packet(OTHER_ID, NET_PC, 10'd64, 32'd0);
        check_idle(1'b1, "PC packet for another core");
        set_mask(16'hffff);

        // Long loop, with foreign and in-run loads that must be ignored
        fill_random_regs();
        reg_init[2] = 32'd40;
        preload_regs();
        load_program(8'd64, 10);
        send_packet(OTHER_ID, NET_INSTR, 10'd65, 32'(encode_r(OP_WAIT, 5'd0, 5'd0)));
        send_packet(OTHER_ID, NET_REG, 10'd2, 32'd1);
        start_program(8'd64);
        for (int k = 0; k < 10; k++)
        begin
            send_packet(CORE_ID, NET_INSTR, 10'(64 + k), 32'(encode_r(OP_WAIT, 5'd0, 5'd0)));
        end
        send_packet(CORE_ID, NET_REG, 10'd1, 32'hdead);
        send_packet(CORE_ID, NET_PC, 10'd70, 32'd0);
        check_idle(1'b0, "still running after ignored packets");
        wait_for_idle();
        request_compare(cur_mask & model_run(8'd64), "loop with ignored packets");

        @(posedge clk);
        #0.5;
        if (i_core_top.i_core_properties.error_count == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            $display("Assertion failures: %0d", i_core_top.i_core_properties.error_count);
            $display("tests failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire
